//--- project.f
+incdir+rtl
rtl/cnn_pkg.sv
rtl/conv_engine.sv
rtl/pool_row_buffer.sv
rtl/pool_max.sv
rtl/clp_top.sv
tb/clp_properties.sv
tb/clp_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= clp_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "no pass result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/clp_tb.sv
`timescale 1ns/100ps
`include "cnn_config.svh"

module clp_tb;

    localparam int K             = `CNN_KERNEL_SIZE;
    localparam int LATENCY       = `CNN_CONV_LATENCY + 2;
    localparam int TOTAL_SAMPLES = 88;
    localparam int WATCHDOG_NS   = TOTAL_SAMPLES * 2 * 20 + 8000;  // margin for resets and drains

    logic                                clk = 1'b0;
    logic                                rst_n;
    logic                                valid_i;
    cnn_pkg::window_t                    window_i;
    cnn_pkg::weight_set_t                weights_i;
    logic signed [`CNN_SCALER_WIDTH-1:0] scaler_i;
    cnn_pkg::chan_vec_t                  bias_i;
    logic [$clog2(`CNN_MAX_ROW+1)-1:0]   row_width_i;
    logic                                out_valid_o;
    cnn_pkg::chan_vec_t                  feature_o;

    logic [15:0]        lfsr_q = 16'd57694;
    int                 mismatch_cnt = 0;
    int                 other_cnt = 0;
    int                 cycle_cnt = 0;
    cnn_pkg::chan_vec_t model_row [`CNN_MAX_ROW];          // reference row buffer
    cnn_pkg::chan_vec_t left_top;
    cnn_pkg::chan_vec_t left_bot;
    int                 model_col;
    bit                 model_odd;
    cnn_pkg::chan_vec_t exp_q [$];
    int                 exp_cycle_q [$];                   // cycle each pooled vector is due

    clp_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .window_i    (window_i),
        .weights_i   (weights_i),
        .scaler_i    (scaler_i),
        .bias_i      (bias_i),
        .row_width_i (row_width_i),
        .out_valid_o (out_valid_o),
        .feature_o   (feature_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic cnn_pkg::window_t rand_window();
        cnn_pkg::window_t w;
        for (int n = 0; n < `CNN_TN; n++)
            for (int r = 0; r < K; r++)
                for (int c = 0; c < K; c++)
                    w[n][r][c] = cnn_pkg::feature_t'(rand_bits(16));
        return w;
    endfunction

    function automatic cnn_pkg::weight_set_t rand_weights();
        cnn_pkg::weight_set_t ws;
        for (int m = 0; m < `CNN_TM; m++)
            for (int n = 0; n < `CNN_TN; n++)
                for (int r = 0; r < K; r++)
                    for (int c = 0; c < K; c++)
                        ws[m][n][r][c] = cnn_pkg::weight_t'(rand_bits(2));
        return ws;
    endfunction

    // conv result from the select, wrap, scale and bias rules
    function automatic cnn_pkg::chan_vec_t conv_model(cnn_pkg::window_t w,
                                                      cnn_pkg::weight_set_t ws);
        cnn_pkg::chan_vec_t res;
        cnn_pkg::feature_t  acc;
        logic signed [31:0] prod;
        for (int m = 0; m < `CNN_TM; m++) begin
            acc = '0;
            for (int n = 0; n < `CNN_TN; n++)
                for (int r = 0; r < K; r++)
                    for (int c = 0; c < K; c++)
                        if (ws[m][n][r][c] == 2'b01) acc = acc + w[n][r][c];
                        else if (ws[m][n][r][c] == 2'b11) acc = acc - w[n][r][c];
            prod = 32'(acc) * 32'(scaler_i);
            prod = prod >>> `CNN_SCALE_SHIFT;
            res[m] = prod[`CNN_FEATURE_WIDTH-1:0] + bias_i[m];
        end
        return res;
    endfunction

    task automatic model_accept(cnn_pkg::chan_vec_t r);
        cnn_pkg::chan_vec_t win;
        cnn_pkg::feature_t  cand [4];
        if (!model_odd) begin
            model_row[model_col] = r;
        end else if (model_col % 2 == 0) begin
            left_top = model_row[model_col];
            left_bot = r;
        end else begin
            for (int m = 0; m < `CNN_TM; m++) begin
                cand = '{left_top[m], left_bot[m], model_row[model_col][m], r[m]};
                win[m] = cand[0];
                for (int i = 1; i < 4; i++)
                    if (cand[i] > win[m]) win[m] = cand[i];
            end
            exp_q.push_back(win);
            exp_cycle_q.push_back(cycle_cnt + LATENCY);
        end
        model_col++;
        if (model_col == int'(row_width_i)) begin
            model_col = 0;
            model_odd = !model_odd;
        end
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_sample(cnn_pkg::window_t w, cnn_pkg::weight_set_t ws);
        valid_i   = 1'b1;
        window_i  = w;
        weights_i = ws;
        model_accept(conv_model(w, ws));
        @(negedge clk);
        valid_i = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n   = 1'b0;
        valid_i = 1'b0;
        repeat (10) @(negedge clk);
        rst_n     = 1'b1;
        model_col = 0;
        model_odd = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (LATENCY) @(negedge clk);
    endtask

    task automatic sign_selection_test();
        logic [1:0]           codes [4];
        cnn_pkg::weight_set_t ws;
        codes = '{2'b01, 2'b11, 2'b10, 2'b00};
        row_width_i = 2;
        scaler_i    = 16'sd256;                          // 1.0
        bias_i      = {cnn_pkg::feature_t'(rand_bits(8)), cnn_pkg::feature_t'(rand_bits(8))};
        for (int s = 0; s < 4; s++) begin
            ws = '0;
            for (int m = 0; m < `CNN_TM; m++)
                ws[m][rand_bits(1)][rand_bits(4) % K][rand_bits(4) % K] = codes[s];
            send_sample(rand_window(), ws);
        end
        drain();
    endtask

    task automatic random_conv_test();
        row_width_i = 8;
        scaler_i    = 16'(rand_bits(16));
        bias_i      = rand_bits(32);
        repeat (32) send_sample(rand_window(), rand_weights());
        drain();
    endtask

    task automatic negative_pool_test();
        cnn_pkg::window_t     w;
        cnn_pkg::weight_set_t ws;
        row_width_i = 2;
        scaler_i    = 16'sd256;
        bias_i      = {-16'sd1000, -16'sd1000};          // every result below zero
        ws = '0;
        for (int m = 0; m < `CNN_TM; m++) ws[m][0][0][0] = 2'b01;
        for (int p = 0; p < 4; p++) begin
            for (int q = 0; q < 4; q++) begin
                w = rand_window();
                w[0][0][0] = (q == p) ? 16'sd100 : cnn_pkg::feature_t'(rand_bits(6));
                send_sample(w, ws);
            end
        end
        drain();
    endtask

    task automatic idle_gap_test();
        row_width_i = 4;
        scaler_i    = 16'(rand_bits(16));
        bias_i      = rand_bits(32);
        for (int s = 0; s < 16; s++) begin
            send_sample(rand_window(), rand_weights());
            repeat (rand_bits(2)) @(negedge clk);
        end
        drain();
    endtask

    task automatic frame_reset_test();
        row_width_i = 4;
        repeat (12) send_sample(rand_window(), rand_weights());   // three rows, parity left odd
        drain();
        apply_reset();
        repeat (8) send_sample(rand_window(), rand_weights());
        drain();
    endtask

    always @(negedge clk) begin
        if (rst_n && out_valid_o) begin
            if (exp_q.size() == 0) begin
                other_cnt++;
                $display("out_valid_o went high but no pooled vector was expected");
            end else begin
                check_value("feature_o", feature_o, exp_q.pop_front());
                check_value("out_valid_o cycle", cycle_cnt, exp_cycle_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    initial begin
        valid_i     = 1'b0;
        window_i    = '0;
        weights_i   = '0;
        scaler_i    = 16'sd256;
        bias_i      = '0;
        row_width_i = 2;
        rst_n       = 1'b0;
        apply_reset();
        sign_selection_test();
        random_conv_test();
        negative_pool_test();
        idle_gap_test();
        frame_reset_test();
        if (exp_q.size() != 0) begin
            other_cnt++;
            $display("%0d expected pooled vectors never appeared", exp_q.size());
        end
        if (i_dut.i_props.fail_cnt != 0) begin
            other_cnt += i_dut.i_props.fail_cnt;
            $display("%0d assertions failed in the bound checker", i_dut.i_props.fail_cnt);
        end
        $display("errors: %0d value mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb/clp_properties.sv
`timescale 1ns/100ps

module clp_properties (
    input logic               clk,
    input logic               rst_n,
    input logic               out_valid_o,
    input cnn_pkg::chan_vec_t feature_o
);

    int fail_cnt = 0;                                     // failed assertions so far

    // output strobe stays low while reset is held
    assert property (@(posedge clk) !rst_n |-> !out_valid_o)
        else begin
            $error("out_valid_o high during reset");
            fail_cnt++;
        end

    // one pooled vector per window, never back to back
    assert property (@(posedge clk) disable iff (!rst_n) out_valid_o |=> !out_valid_o)
        else begin
            $error("out_valid_o high on two consecutive cycles");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid_o |-> !$isunknown(feature_o))
        else begin
            $error("feature_o unknown while out_valid_o is high");
            fail_cnt++;
        end

endmodule

bind clp_top clp_properties i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_valid_o (out_valid_o),
    .feature_o   (feature_o)
);

//--- rtl/clp_top.sv
`timescale 1ns/100ps
`include "cnn_config.svh"

module clp_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 valid_i,
    input  cnn_pkg::window_t                     window_i,
    input  cnn_pkg::weight_set_t                 weights_i,
    input  logic signed [`CNN_SCALER_WIDTH-1:0]  scaler_i,
    input  cnn_pkg::chan_vec_t                   bias_i,
    input  logic [$clog2(`CNN_MAX_ROW+1)-1:0]    row_width_i,
    output logic                                 out_valid_o,
    output cnn_pkg::chan_vec_t                   feature_o
);

    logic               conv_valid;
    cnn_pkg::chan_vec_t conv_data;
    logic               pair_valid;
    logic               pair_last_col;
    cnn_pkg::chan_vec_t pair_top;
    cnn_pkg::chan_vec_t pair_bottom;

    conv_engine u_conv_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .window_i     (window_i),
        .weights_i    (weights_i),
        .scaler_i     (scaler_i),
        .bias_i       (bias_i),
        .conv_valid_o (conv_valid),
        .conv_data_o  (conv_data)
    );

    pool_row_buffer u_pool_row_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .conv_valid_i    (conv_valid),
        .conv_data_i     (conv_data),
        .row_width_i     (row_width_i),
        .pair_valid_o    (pair_valid),
        .pair_last_col_o (pair_last_col),
        .pair_top_o      (pair_top),
        .pair_bottom_o   (pair_bottom)
    );

    pool_max u_pool_max (
        .clk             (clk),
        .rst_n           (rst_n),
        .pair_valid_i    (pair_valid),
        .pair_last_col_i (pair_last_col),
        .pair_top_i      (pair_top),
        .pair_bottom_i   (pair_bottom),
        .out_valid_o     (out_valid_o),
        .feature_o       (feature_o)
    );

endmodule

//--- rtl/pool_max.sv
`timescale 1ns/100ps
`include "cnn_config.svh"

module pool_max (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pair_valid_i,
    input  logic               pair_last_col_i,
    input  cnn_pkg::chan_vec_t pair_top_i,
    input  cnn_pkg::chan_vec_t pair_bottom_i,
    output logic               out_valid_o,
    output cnn_pkg::chan_vec_t feature_o
);

    cnn_pkg::chan_vec_t pair_max;
    cnn_pkg::chan_vec_t win_max;
    cnn_pkg::chan_vec_t held_q;                           // max of the first column

    function automatic cnn_pkg::feature_t max_f(cnn_pkg::feature_t a, cnn_pkg::feature_t b);
        max_f = (a > b) ? a : b;                          // signed compare
    endfunction

    always_comb begin
        for (int c = 0; c < `CNN_TM; c++) begin
            pair_max[c] = max_f(pair_top_i[c], pair_bottom_i[c]);
            win_max[c]  = max_f(held_q[c], pair_max[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (pair_valid_i && !pair_last_col_i) begin
            held_q <= pair_max;
        end
        if (pair_valid_i && pair_last_col_i) begin
            feature_o <= win_max;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= pair_valid_i && pair_last_col_i;
        end
    end

endmodule

//--- rtl/pool_row_buffer.sv
`timescale 1ns/100ps
`include "cnn_config.svh"

module pool_row_buffer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 conv_valid_i,
    input  cnn_pkg::chan_vec_t                   conv_data_i,
    input  logic [$clog2(`CNN_MAX_ROW+1)-1:0]    row_width_i,
    output logic                                 pair_valid_o,
    output logic                                 pair_last_col_o,
    output cnn_pkg::chan_vec_t                   pair_top_o,
    output cnn_pkg::chan_vec_t                   pair_bottom_o
);

    localparam int COL_W = $clog2(`CNN_MAX_ROW);

    logic [COL_W-1:0]   col_q;
    logic               odd_row_q;
    logic               row_end;
    cnn_pkg::chan_vec_t row_mem [`CNN_MAX_ROW];          // one even row of results

    assign row_end = ({1'b0, col_q} == row_width_i - 1'b1);

    // column counter and row parity
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q        <= '0;
            odd_row_q    <= 1'b0;
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= conv_valid_i && odd_row_q;
            if (conv_valid_i) begin
                if (row_end) begin
                    col_q     <= '0;
                    odd_row_q <= !odd_row_q;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (conv_valid_i && !odd_row_q) begin
            row_mem[col_q] <= conv_data_i;
        end
    end

    // odd row: pair the new result with the one stored above it
    always_ff @(posedge clk) begin
        if (conv_valid_i && odd_row_q) begin
            pair_top_o      <= row_mem[col_q];
            pair_bottom_o   <= conv_data_i;
            pair_last_col_o <= col_q[0];                  // second column of a window
        end
    end

endmodule

//--- rtl/conv_engine.sv
`timescale 1ns/100ps
`include "cnn_config.svh"

module conv_engine (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                valid_i,
    input  cnn_pkg::window_t                    window_i,
    input  cnn_pkg::weight_set_t                weights_i,
    input  logic signed [`CNN_SCALER_WIDTH-1:0] scaler_i,
    input  cnn_pkg::chan_vec_t                  bias_i,
    output logic                                conv_valid_o,
    output cnn_pkg::chan_vec_t                  conv_data_o
);

    localparam int K      = `CNN_KERNEL_SIZE;
    localparam int K2     = K * K;
    localparam int LEVELS = $clog2(K2);                  // registered adder levels
    localparam int LEAVES = 2 ** LEVELS;                 // tree padded with zeros
    localparam int PROD_W = `CNN_FEATURE_WIDTH + `CNN_SCALER_WIDTH;

    logic [`CNN_CONV_LATENCY-1:0] valid_sr;

    cnn_pkg::feature_t             tree_q [`CNN_TM][`CNN_TN][LEVELS+1][LEAVES];
    cnn_pkg::feature_t             chan_sum_d [`CNN_TM];
    cnn_pkg::feature_t             chan_sum_q [`CNN_TM];
    logic signed [PROD_W-1:0]      prod_d [`CNN_TM];
    cnn_pkg::feature_t             scaled_q [`CNN_TM];
    cnn_pkg::chan_vec_t            biased_q;

    function automatic cnn_pkg::feature_t ternary_sel(cnn_pkg::feature_t f,
                                                      cnn_pkg::weight_t  w);
        case (w)
            2'b01:   ternary_sel = f;
            2'b11:   ternary_sel = -f;
            default: ternary_sel = '0;
        endcase
    endfunction

    // select stage and adder tree, one tree per output/input channel pair
    always_ff @(posedge clk) begin
        for (int m = 0; m < `CNN_TM; m++) begin
            for (int n = 0; n < `CNN_TN; n++) begin
                for (int p = 0; p < LEAVES; p++) begin
                    if (p < K2) begin
                        tree_q[m][n][0][p] <= ternary_sel(window_i[n][p / K][p % K],
                                                          weights_i[m][n][p / K][p % K]);
                    end else begin
                        tree_q[m][n][0][p] <= '0;
                    end
                end
                for (int l = 0; l < LEVELS; l++) begin
                    for (int j = 0; j < (LEAVES >> (l + 1)); j++) begin
                        tree_q[m][n][l+1][j] <= tree_q[m][n][l][2*j] + tree_q[m][n][l][2*j+1];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int m = 0; m < `CNN_TM; m++) begin
            chan_sum_d[m] = '0;
            for (int n = 0; n < `CNN_TN; n++) begin
                chan_sum_d[m] = chan_sum_d[m] + tree_q[m][n][LEVELS][0];
            end
            prod_d[m] = chan_sum_q[m] * scaler_i;         // full signed product
        end
    end

    // channel sum, scale and bias stages
    always_ff @(posedge clk) begin
        for (int m = 0; m < `CNN_TM; m++) begin
            chan_sum_q[m] <= chan_sum_d[m];
            // arithmetic shift then truncate to feature width
            scaled_q[m]   <= prod_d[m][`CNN_SCALE_SHIFT +: `CNN_FEATURE_WIDTH];
            biased_q[m]   <= scaled_q[m] + bias_i[m];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`CNN_CONV_LATENCY-2:0], valid_i};
        end
    end

    assign conv_valid_o = valid_sr[`CNN_CONV_LATENCY-1];
    assign conv_data_o  = biased_q;

endmodule

//--- rtl/cnn_pkg.sv
`include "cnn_config.svh"

package cnn_pkg;

    typedef logic signed [`CNN_FEATURE_WIDTH-1:0] feature_t;

    // 01 -> +f, 11 -> -f, 00/10 -> 0
    typedef logic [1:0] weight_t;

    // [channel][row][col]
    typedef feature_t [`CNN_TN-1:0][`CNN_KERNEL_SIZE-1:0][`CNN_KERNEL_SIZE-1:0] window_t;

    // [out channel][in channel][row][col]
    typedef weight_t [`CNN_TM-1:0][`CNN_TN-1:0]
                     [`CNN_KERNEL_SIZE-1:0][`CNN_KERNEL_SIZE-1:0] weight_set_t;

    // one value per output channel
    typedef feature_t [`CNN_TM-1:0] chan_vec_t;

endpackage

//--- rtl/cnn_config.svh
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// datapath widths
`define CNN_FEATURE_WIDTH 16      // feature, sum, bias and result
`define CNN_SCALER_WIDTH  16      // signed fixed-point scaler
`define CNN_SCALE_SHIFT   8       // fraction bits of the scaler

// geometry
`define CNN_KERNEL_SIZE   3
`define CNN_TN            2       // input channels
`define CNN_TM            2       // output channels
`define CNN_MAX_ROW       32      // widest conv-output row

`define CNN_CONV_LATENCY  8       // select + 4 tree levels + channel sum + scale + bias

`endif
